/* Bender.yml */
package:
  name: sprite_subsystem

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/gfx_pkg.sv
      - hdl/cmd_pkg.sv
      - hdl/sprite_cmd_decoder.sv
      - hdl/sprite_engine.sv
      - hdl/frame_buffer.sv
      - hdl/sprite_subsystem.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/sprite_tb.sv

/* hdl/cmd_pkg.sv */
// Host command types
package cmd_pkg;

    // Opcode is the first byte of every command frame
    //   SET_POSITION  x high, x low, y high, y low
    //   SET_WIDTH     width high, width low
    //   SET_COLORS    mode in bits 5:4, palette offset in bits 3:0
    //   DRAW          any number of packed pixel bytes
    typedef enum logic [7:0] {
        SET_POSITION = 8'h10,
        SET_WIDTH    = 8'h11,
        SET_COLORS   = 8'h12,
        DRAW         = 8'h20
    } opcode_t;

    // High bytes of position and width carry only their top 2 bits
    localparam int unsigned HIGH_BYTE_BITS = 2;

    // Argument bytes following each SET opcode
    localparam int unsigned POSITION_ARGS = 4;
    localparam int unsigned WIDTH_ARGS    = 2;
    localparam int unsigned COLORS_ARGS   = 1;

    // One byte from the host with its one-cycle valid strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } host_byte_t;

endpackage

/* hdl/display_defines.svh */
// Display geometry and pixel timing
`ifndef DISPLAY_DEFINES_SVH
`define DISPLAY_DEFINES_SVH

// Pixels per display row, used for the row stride of the frame buffer
`define SCREEN_WIDTH 640

// Display rows held in the frame buffer
`define SCREEN_HEIGHT 400

// Frame buffer entries, one pixel each (640 by 400)
`define FB_DEPTH 256000

// Address width needed to reach every frame buffer entry
`define FB_ADDR_W 18

// Clocks per pixel written by the sprite engine
`define PIXEL_DIV 2

`endif

/* hdl/frame_buffer.sv */
// Sprite frame buffer
`timescale 1ns/1ps
`include "display_defines.svh"

module frame_buffer (
    input  logic                  clock_in,
    input  gfx_pkg::pixel_write_t pixel_write,
    input  logic [`FB_ADDR_W-1:0] read_address,
    output gfx_pkg::pixel_t       read_data
);

    import gfx_pkg::*;

    localparam int unsigned DEPTH = `FB_DEPTH;

    // One palette index per screen pixel, row after row
    pixel_t memory [DEPTH];

    // Screen starts out cleared to palette entry zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            memory[i] = '0;
        end
    end

    // Write port, one pixel per enable pulse
    always_ff @(posedge clock_in) begin
        if (pixel_write.enable) begin
            memory[pixel_write.address] <= pixel_write.pixel;
        end
    end

    // Read port for display and readback, one clock of latency
    always_ff @(posedge clock_in) begin
        read_data <= memory[read_address];
    end

endmodule

/* hdl/gfx_pkg.sv */
// Graphics types
`include "display_defines.svh"

package gfx_pkg;

    // 4-bit palette index as stored in the frame buffer
    typedef logic [3:0] pixel_t;

    // Bits per pixel of packed sprite data
    typedef enum logic [1:0] {
        COLOR_1BPP = 2'd0,
        COLOR_2BPP = 2'd1,
        COLOR_4BPP = 2'd2
    } color_mode_t;

    // Sprite placement and color setup, written by SET commands
    typedef struct packed {
        logic [9:0]  x_start;
        logic [9:0]  y_start;
        logic [9:0]  width;
        color_mode_t mode;
        pixel_t      palette_offset;
    } sprite_cfg_t;

    // One pixel write into the frame buffer
    typedef struct packed {
        logic                    enable;
        logic [`FB_ADDR_W-1:0]   address;
        pixel_t                  pixel;
    } pixel_write_t;

    // Same data byte, seen as 8, 4 or 2 palette indices
    // Highest element is the leftmost pixel on screen
    typedef union packed {
        logic [7:0]      bpp1;
        logic [3:0][1:0] bpp2;
        logic [1:0][3:0] bpp4;
    } pixel_byte_u;

endpackage

/* hdl/sprite_cmd_decoder.sv */
// Sprite command decoder
`timescale 1ns/1ps

module sprite_cmd_decoder (
    input  logic                 clock_in,
    input  logic                 reset,
    input  logic                 frame_active,
    input  cmd_pkg::host_byte_t  host_byte,
    output gfx_pkg::sprite_cfg_t cfg,
    output logic                 draw_enable,
    output cmd_pkg::host_byte_t  data_byte
);

    import cmd_pkg::*;
    import gfx_pkg::*;

    localparam logic [1:0] ST_OPCODE = 2'd0;
    localparam logic [1:0] ST_ARGS   = 2'd1;
    localparam logic [1:0] ST_DRAW   = 2'd2;
    localparam logic [1:0] ST_IGNORE = 2'd3;

    logic [1:0]  state;
    opcode_t     opcode;
    logic [1:0]  arg_index;
    logic        last_arg;
    logic [23:0] arg_shift;
    logic        data_valid_q;
    logic [7:0]  data_q;

    // Compare the argument count against what the current opcode takes
    always_comb begin
        case (opcode)
            SET_POSITION: last_arg = (arg_index == 2'(POSITION_ARGS - 1));
            SET_WIDTH:    last_arg = (arg_index == 2'(WIDTH_ARGS - 1));
            default:      last_arg = (arg_index == 2'(COLORS_ARGS - 1));
        endcase
    end

    always_ff @(posedge clock_in) begin
        if (reset) begin
            state        <= ST_OPCODE;
            opcode       <= SET_COLORS;
            arg_index    <= '0;
            draw_enable  <= 1'b0;
            data_valid_q <= 1'b0;
            cfg          <= '0;
        end else if (!frame_active) begin
            // Wait for the next opcode between frames
            state        <= ST_OPCODE;
            arg_index    <= '0;
            draw_enable  <= 1'b0;
            data_valid_q <= 1'b0;
        end else begin
            data_valid_q <= host_byte.valid && (state == ST_DRAW);
            if (host_byte.valid) begin
                case (state)
                    ST_OPCODE: begin
                        opcode    <= opcode_t'(host_byte.data);
                        arg_index <= '0;
                        case (host_byte.data)
                            SET_POSITION, SET_WIDTH, SET_COLORS: state <= ST_ARGS;
                            DRAW: begin
                                state       <= ST_DRAW;
                                draw_enable <= 1'b1;
                            end
                            // Unknown opcode drops the rest of the frame
                            default: state <= ST_IGNORE;
                        endcase
                    end
                    ST_ARGS: begin
                        if (last_arg) begin
                            state <= ST_IGNORE;
                            case (opcode)
                                SET_POSITION: begin
                                    cfg.x_start <= {arg_shift[16 +: HIGH_BYTE_BITS],
                                                    arg_shift[15:8]};
                                    cfg.y_start <= {arg_shift[0 +: HIGH_BYTE_BITS],
                                                    host_byte.data};
                                end
                                SET_WIDTH: begin
                                    cfg.width <= {arg_shift[0 +: HIGH_BYTE_BITS],
                                                  host_byte.data};
                                end
                                default: begin
                                    cfg.mode           <= color_mode_t'(host_byte.data[5:4]);
                                    cfg.palette_offset <= host_byte.data[3:0];
                                end
                            endcase
                        end else begin
                            arg_index <= arg_index + 2'd1;
                        end
                    end
                    default: begin
                        // Draw bytes leave as data strobes and surplus bytes are dropped
                    end
                endcase
            end
        end
    end

    // Last three host bytes that feed the SET argument fields
    always_ff @(posedge clock_in) begin
        if (host_byte.valid) begin
            arg_shift <= {arg_shift[15:0], host_byte.data};
        end
        data_q <= host_byte.data;
    end

    assign data_byte = '{valid: data_valid_q, data: data_q};

endmodule

/* hdl/sprite_engine.sv */
// Sprite pixel engine
`timescale 1ns/1ps
`include "display_defines.svh"

module sprite_engine (
    input  logic                  clock_in,
    input  logic                  reset,
    input  logic                  draw_enable,
    input  gfx_pkg::sprite_cfg_t  cfg,
    input  cmd_pkg::host_byte_t   data_byte,
    output gfx_pkg::pixel_write_t pixel_write,
    output logic                  busy
);

    import gfx_pkg::*;

    localparam int unsigned ADDR_W   = `FB_ADDR_W;
    localparam logic [3:0]  DIV_LAST = 4'(`PIXEL_DIV - 1);

    pixel_byte_u         unpack_q;
    logic [3:0]          pixels_left;
    logic [3:0]          load_count;
    logic [2:0]          pixel_index;
    logic [3:0]          div_count;
    logic                draw_prev;
    logic [9:0]          pen_x;
    logic [9:0]          pen_y;
    logic [9:0]          col_count;
    pixel_t              next_index;
    pixel_t              next_pixel;
    logic [ADDR_W-1:0]   pen_address;
    logic                write_enable_q;
    logic [ADDR_W-1:0]   write_address_q;
    pixel_t              write_pixel_q;

    // Pixels packed in one byte
    always_comb begin
        case (cfg.mode)
            COLOR_1BPP: load_count = 4'd8;
            COLOR_2BPP: load_count = 4'd4;
            default:    load_count = 4'd2;
        endcase
    end

    // Leftmost pixel sits in the most significant bits
    always_comb begin
        case (cfg.mode)
            COLOR_1BPP: next_index = {3'b000, unpack_q.bpp1[3'd7 - pixel_index]};
            COLOR_2BPP: next_index = {2'b00, unpack_q.bpp2[2'd3 - pixel_index[1:0]]};
            default:    next_index = unpack_q.bpp4[1'd1 - pixel_index[0]];
        endcase
    end

    // Palette offset wraps inside the 16-entry palette
    assign next_pixel = next_index + cfg.palette_offset;

    assign pen_address = ADDR_W'(pen_y) * ADDR_W'(`SCREEN_WIDTH) + ADDR_W'(pen_x);

    always_ff @(posedge clock_in) begin
        if (reset || !draw_enable) begin
            draw_prev      <= 1'b0;
            pixels_left    <= '0;
            pixel_index    <= '0;
            div_count      <= '0;
            col_count      <= '0;
            pen_x          <= '0;
            pen_y          <= '0;
            write_enable_q <= 1'b0;
        end else begin
            draw_prev      <= 1'b1;
            write_enable_q <= 1'b0;

            // New draw starts at the configured corner
            if (!draw_prev) begin
                pen_x     <= cfg.x_start;
                pen_y     <= cfg.y_start;
                col_count <= '0;
            end

            if (data_byte.valid) begin
                // A new byte replaces whatever is left of the old one
                pixels_left <= load_count;
                pixel_index <= '0;
                div_count   <= '0;
            end else if (pixels_left != 4'd0) begin
                if (div_count == 4'd0) begin
                    write_enable_q <= 1'b1;
                    pixels_left    <= pixels_left - 4'd1;
                    pixel_index    <= pixel_index + 3'd1;
                    div_count      <= DIV_LAST;

                    // Row wrap after width pixels
                    if (col_count + 10'd1 >= cfg.width) begin
                        col_count <= '0;
                        pen_x     <= cfg.x_start;
                        pen_y     <= pen_y + 10'd1;
                    end else begin
                        col_count <= col_count + 10'd1;
                        pen_x     <= pen_x + 10'd1;
                    end
                end else begin
                    div_count <= div_count - 4'd1;
                end
            end
        end
    end

    // Pixel data and byte store, qualified by the enable and the strobe
    always_ff @(posedge clock_in) begin
        if (data_byte.valid) begin
            unpack_q <= data_byte.data;
        end
        write_address_q <= pen_address;
        write_pixel_q   <= next_pixel;
    end

    assign pixel_write = '{enable: write_enable_q, address: write_address_q,
                           pixel: write_pixel_q};

    assign busy = (pixels_left != 4'd0);

endmodule

/* hdl/sprite_subsystem.sv */
// Sprite drawing subsystem
`timescale 1ns/1ps
`include "display_defines.svh"

module sprite_subsystem (
    input  logic                  clock_in,
    input  logic                  reset,
    input  logic                  frame_active,
    input  cmd_pkg::host_byte_t   host_byte,
    input  logic [`FB_ADDR_W-1:0] read_address,
    output gfx_pkg::pixel_t       read_data,
    output logic                  busy
);

    import cmd_pkg::*;
    import gfx_pkg::*;

    sprite_cfg_t  cfg;
    logic         draw_enable;
    host_byte_t   data_byte;
    pixel_write_t pixel_write;

    // Host frames to configuration and data strobes
    sprite_cmd_decoder u_decoder (
        .clock_in     (clock_in),
        .reset        (reset),
        .frame_active (frame_active),
        .host_byte    (host_byte),
        .cfg          (cfg),
        .draw_enable  (draw_enable),
        .data_byte    (data_byte)
    );

    // Data bytes to pixel writes
    sprite_engine u_engine (
        .clock_in    (clock_in),
        .reset       (reset),
        .draw_enable (draw_enable),
        .cfg         (cfg),
        .data_byte   (data_byte),
        .pixel_write (pixel_write),
        .busy        (busy)
    );

    frame_buffer u_frame_buffer (
        .clock_in     (clock_in),
        .pixel_write  (pixel_write),
        .read_address (read_address),
        .read_data    (read_data)
    );

endmodule

/* tb.f */
+incdir+hdl
hdl/gfx_pkg.sv
hdl/cmd_pkg.sv
hdl/sprite_cmd_decoder.sv
hdl/sprite_engine.sv
hdl/frame_buffer.sv
hdl/sprite_subsystem.sv
verif/sprite_tb.sv

/* verif/sprite_tb.sv */
// Sprite subsystem testbench
`timescale 1ns/1ps
`include "display_defines.svh"

module sprite_tb;

    import gfx_pkg::*;
    import cmd_pkg::*;

    localparam int NUM_CASES = 6;
    localparam int WAIT_LIMIT = 2000;

    // Minimum host spacing of data strobes in clocks
    localparam int BYTE_GAP = 20;

    // One sprite draw with its data in fixed_data (first byte on top) or from the generator
    typedef struct packed {
        logic [9:0]  x;
        logic [9:0]  y;
        logic [9:0]  width;
        color_mode_t mode;
        pixel_t      offset;
        logic [3:0]  byte_count;
        logic        random_data;
        logic [63:0] fixed_data;
    } sprite_case_t;

    localparam sprite_case_t CASE_TABLE [NUM_CASES] = '{
        '{x: 10'd20, y: 10'd10, width: 10'd8, mode: COLOR_1BPP, offset: 4'd3,
          byte_count: 4'd2, random_data: 1'b0, fixed_data: 64'hA53C_0000_0000_0000},
        '{x: 10'd50, y: 10'd30, width: 10'd8, mode: COLOR_2BPP, offset: 4'd0,
          byte_count: 4'd6, random_data: 1'b1, fixed_data: 64'h0},
        '{x: 10'd100, y: 10'd40, width: 10'd4, mode: COLOR_4BPP, offset: 4'd9,
          byte_count: 4'd4, random_data: 1'b0, fixed_data: 64'h0F7E_C396_0000_0000},
        // Width 5 against 4 pixels per byte splits rows inside bytes
        '{x: 10'd200, y: 10'd60, width: 10'd5, mode: COLOR_2BPP, offset: 4'd5,
          byte_count: 4'd4, random_data: 1'b0, fixed_data: 64'h1BE4_729C_0000_0000},
        // Lands on top of the previous sprite
        '{x: 10'd202, y: 10'd61, width: 10'd7, mode: COLOR_1BPP, offset: 4'd1,
          byte_count: 4'd3, random_data: 1'b1, fixed_data: 64'h0},
        '{x: 10'd300, y: 10'd100, width: 10'd3, mode: COLOR_4BPP, offset: 4'd2,
          byte_count: 4'd3, random_data: 1'b1, fixed_data: 64'h0}
    };

    logic                  clock_in = 1'b0;
    logic                  reset;
    logic                  frame_active;
    host_byte_t            host_byte;
    logic [`FB_ADDR_W-1:0] read_address;
    pixel_t                read_data;
    logic                  busy;

    logic [31:0] rng_state;
    logic [7:0]  draw_bytes [8];
    pixel_t      shadow [`FB_DEPTH];

    sprite_subsystem u_dut (
        .clock_in     (clock_in),
        .reset        (reset),
        .frame_active (frame_active),
        .host_byte    (host_byte),
        .read_address (read_address),
        .read_data    (read_data),
        .busy         (busy)
    );

    always #20 clock_in = ~clock_in;

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic fail_stop(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pixel(input int address, input pixel_t expected, input pixel_t actual);
        if (actual !== expected) begin
            $display("error at time %0t: address %0d expected %h got %h",
                     $time, address, expected, actual);
            fail_stop("pixel readback mismatch");
        end
    endtask

    task automatic check_level(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error at time %0t: %s expected %b got %b", $time, what, expected, actual);
            fail_stop("control signal mismatch");
        end
    endtask

    task automatic wait_busy(input logic level);
        int count;
        count = 0;
        while (1) begin
            @(negedge clock_in);
            if (busy === level) begin
                break;
            end
            count++;
            if (count >= WAIT_LIMIT) begin
                fail_stop($sformatf("timeout waiting for busy to become %b", level));
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        @(posedge clock_in);
        host_byte <= '{valid: 1'b1, data: value};
        @(posedge clock_in);
        host_byte <= '{valid: 1'b0, data: 8'h00};
    endtask

    task automatic begin_frame();
        @(posedge clock_in);
        frame_active <= 1'b1;
    endtask

    // Gap between frames is longer than the 4 clocks the host must leave
    task automatic end_frame();
        @(posedge clock_in);
        frame_active <= 1'b0;
        repeat (6) @(posedge clock_in);
    endtask

    function automatic int bits_per_pixel(input color_mode_t mode);
        case (mode)
            COLOR_1BPP: return 1;
            COLOR_2BPP: return 2;
            default:    return 4;
        endcase
    endfunction

    // Shadow copy of the frame buffer with the pen starting at the sprite corner
    task automatic model_draw(input sprite_case_t sc);
        int bits;
        int pen_x;
        int pen_y;
        int col;
        int index;
        bits  = bits_per_pixel(sc.mode);
        pen_x = sc.x;
        pen_y = sc.y;
        col   = 0;
        for (int b = 0; b < sc.byte_count; b++) begin
            for (int k = 0; k < 8 / bits; k++) begin
                index = (draw_bytes[b] >> (8 - bits * (k + 1))) & ((1 << bits) - 1);
                shadow[pen_y * `SCREEN_WIDTH + pen_x] = pixel_t'(index + sc.offset);
                col++;
                if (col >= sc.width) begin
                    col   = 0;
                    pen_x = sc.x;
                    pen_y++;
                end else begin
                    pen_x++;
                end
            end
        end
    endtask

    task automatic read_box(input sprite_case_t sc);
        int pixels;
        int rows;
        int address;
        pixels = sc.byte_count * (8 / bits_per_pixel(sc.mode));
        rows   = (pixels + sc.width - 1) / sc.width;
        // One pixel border around the box must keep its old contents
        for (int yy = sc.y - 1; yy <= sc.y + rows; yy++) begin
            for (int xx = sc.x - 1; xx <= sc.x + sc.width; xx++) begin
                address = yy * `SCREEN_WIDTH + xx;
                @(posedge clock_in);
                read_address <= address[`FB_ADDR_W-1:0];
                @(posedge clock_in);
                @(negedge clock_in);
                check_pixel(address, shadow[address], read_data);
            end
        end
    endtask

    task automatic run_case(input sprite_case_t sc);
        for (int b = 0; b < sc.byte_count; b++) begin
            if (sc.random_data) begin
                rng_state     = next_random(rng_state);
                draw_bytes[b] = rng_state[7:0];
            end else begin
                draw_bytes[b] = sc.fixed_data[63 - 8 * b -: 8];
            end
        end
        model_draw(sc);

        begin_frame();
        send_byte(SET_POSITION);
        send_byte({6'b0, sc.x[9:8]});
        send_byte(sc.x[7:0]);
        send_byte({6'b0, sc.y[9:8]});
        send_byte(sc.y[7:0]);
        end_frame();

        begin_frame();
        send_byte(SET_WIDTH);
        send_byte({6'b0, sc.width[9:8]});
        send_byte(sc.width[7:0]);
        end_frame();

        begin_frame();
        send_byte(SET_COLORS);
        send_byte({2'b00, sc.mode, sc.offset});
        end_frame();

        begin_frame();
        send_byte(DRAW);
        repeat (2) @(posedge clock_in);
        // Each byte drains and then idles for the full strobe spacing
        for (int b = 0; b < sc.byte_count; b++) begin
            send_byte(draw_bytes[b]);
            wait_busy(1'b1);
            wait_busy(1'b0);
            repeat (BYTE_GAP) @(posedge clock_in);
        end
        end_frame();

        read_box(sc);
    endtask

    initial begin
        reset        = 1'b1;
        frame_active = 1'b0;
        host_byte    = '0;
        read_address = '0;
        rng_state    = 32'hdcae_cb01;
        for (int i = 0; i < `FB_DEPTH; i++) begin
            shadow[i] = '0;
        end

        repeat (2) @(posedge clock_in);
        reset <= 1'b0;
        @(negedge clock_in);
        check_level("busy after reset", 1'b0, busy);

        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(CASE_TABLE[c]);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule
